/* common/core_pkg.sv */
// Core widths, opcode, ALU operation, branch and writeback-select encodings
`default_nettype none

package core_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------
    localparam int XLEN      = 32;
    localparam int REG_IDX_W = 5;

    // ----------------------------------------
    // Encodings
    // ----------------------------------------
    // Major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_XOR,
        ALU_SRL,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_JUMP
    } br_op_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_PC4
    } wb_sel_e;

    // ADDI x0, x0, 0
    localparam logic [XLEN-1:0] NOP_INSN = 32'h0000_0013;

endpackage

`default_nettype wire

/* logic/regfile.sv */
// Register file with 31 writable registers, hardwired x0 and write-through reads
`timescale 1ns/100ps
`default_nettype none

module regfile
    import core_pkg::*;
(
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 we_i,
    input  wire logic [REG_IDX_W-1:0] waddr_i,
    input  wire logic [XLEN-1:0]      wdata_i,
    input  wire logic [REG_IDX_W-1:0] raddr1_i,
    input  wire logic [REG_IDX_W-1:0] raddr2_i,
    output logic      [XLEN-1:0]      rdata1_o,
    output logic      [XLEN-1:0]      rdata2_o
);

    logic [XLEN-1:0] regs [1:2**REG_IDX_W-1];

    // x0 is never stored
    always_ff @(posedge clk) begin
        if (we_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // Same-cycle write bypasses the array
    function automatic logic [XLEN-1:0] read_port(input logic [REG_IDX_W-1:0] addr);
        if (addr == '0) begin
            return '0;
        end
        if (we_i && (waddr_i == addr)) begin
            return wdata_i;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rdata1_o = read_port(raddr1_i);
        rdata2_o = read_port(raddr2_i);
    end

    a_x0_reads_zero: assert property (@(posedge clk) disable iff (!rst_n)
        ((raddr1_i != '0) || (rdata1_o == '0)) && ((raddr2_i != '0) || (rdata2_o == '0)))
        else $error("regfile: x0 read returned nonzero");

endmodule

`default_nettype wire

/* pipeline/decode_unit.sv */
// Instruction decoder for the RV32I subset: register indexes, immediate, control fields
`timescale 1ns/100ps
`default_nettype none

module decode_unit
    import core_pkg::*;
(
    input  wire logic [XLEN-1:0]      insn_i,
    output logic      [REG_IDX_W-1:0] rs1_o,
    output logic      [REG_IDX_W-1:0] rs2_o,
    output logic      [REG_IDX_W-1:0] rd_o,
    output logic      [XLEN-1:0]      imm_o,
    output alu_op_e                   alu_op_o,
    output br_op_e                    br_op_o,
    output logic                      alu_src_imm_o,
    output logic                      uses_rs2_o,
    output logic                      mem_read_o,
    output logic                      mem_write_o,
    output logic                      wb_en_o,
    output wb_sel_e                   wb_sel_o
);

    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [XLEN-1:0] imm_i_fmt;
    logic [XLEN-1:0] imm_s_fmt;
    logic [XLEN-1:0] imm_b_fmt;
    logic [XLEN-1:0] imm_u_fmt;
    logic [XLEN-1:0] imm_j_fmt;

    assign funct3 = insn_i[14:12];
    assign funct7 = insn_i[31:25];

    // Immediate formats
    assign imm_i_fmt = {{20{insn_i[31]}}, insn_i[31:20]};
    assign imm_s_fmt = {{20{insn_i[31]}}, insn_i[31:25], insn_i[11:7]};
    assign imm_b_fmt = {{19{insn_i[31]}}, insn_i[31], insn_i[7], insn_i[30:25],
                        insn_i[11:8], 1'b0};
    assign imm_u_fmt = {insn_i[31:12], 12'h000};
    assign imm_j_fmt = {{11{insn_i[31]}}, insn_i[31], insn_i[19:12], insn_i[20],
                        insn_i[30:21], 1'b0};

    always_comb begin
        rs1_o         = insn_i[19:15];
        rs2_o         = insn_i[24:20];
        rd_o          = insn_i[11:7];
        imm_o         = imm_i_fmt;
        alu_op_o      = ALU_ADD;
        br_op_o       = BR_NONE;
        alu_src_imm_o = 1'b0;
        uses_rs2_o    = 1'b0;
        mem_read_o    = 1'b0;
        mem_write_o   = 1'b0;
        wb_en_o       = 1'b0;
        wb_sel_o      = WB_ALU;
        case (insn_i[6:0])
            OPC_LUI: begin
                // No source register, avoids false load-use stalls
                rs1_o         = '0;
                imm_o         = imm_u_fmt;
                alu_op_o      = ALU_PASS_B;
                alu_src_imm_o = 1'b1;
                wb_en_o       = 1'b1;
            end
            OPC_OP_IMM: begin
                alu_src_imm_o = 1'b1;
                wb_en_o       = 1'b1;
                case (funct3)
                    3'b000:  alu_op_o = ALU_ADD;
                    3'b010:  alu_op_o = ALU_SLT;
                    3'b100:  alu_op_o = ALU_XOR;
                    3'b110:  alu_op_o = ALU_OR;
                    3'b111:  alu_op_o = ALU_AND;
                    default: wb_en_o  = 1'b0;
                endcase
            end
            OPC_OP: begin
                uses_rs2_o = 1'b1;
                wb_en_o    = 1'b1;
                case ({funct7, funct3})
                    {7'h00, 3'b000}: alu_op_o = ALU_ADD;
                    {7'h20, 3'b000}: alu_op_o = ALU_SUB;
                    {7'h00, 3'b001}: alu_op_o = ALU_SLL;
                    {7'h00, 3'b010}: alu_op_o = ALU_SLT;
                    {7'h00, 3'b100}: alu_op_o = ALU_XOR;
                    {7'h00, 3'b101}: alu_op_o = ALU_SRL;
                    {7'h00, 3'b110}: alu_op_o = ALU_OR;
                    {7'h00, 3'b111}: alu_op_o = ALU_AND;
                    default:         wb_en_o  = 1'b0;
                endcase
            end
            OPC_LOAD: begin
                alu_src_imm_o = 1'b1;
                mem_read_o    = (funct3 == 3'b010);
                wb_en_o       = (funct3 == 3'b010);
                wb_sel_o      = WB_MEM;
            end
            OPC_STORE: begin
                imm_o         = imm_s_fmt;
                alu_src_imm_o = 1'b1;
                uses_rs2_o    = 1'b1;
                mem_write_o   = (funct3 == 3'b010);
            end
            OPC_BRANCH: begin
                imm_o      = imm_b_fmt;
                uses_rs2_o = 1'b1;
                case (funct3)
                    3'b000:  br_op_o = BR_EQ;
                    3'b001:  br_op_o = BR_NE;
                    3'b100:  br_op_o = BR_LT;
                    default: br_op_o = BR_NONE;
                endcase
            end
            OPC_JAL: begin
                rs1_o    = '0;
                imm_o    = imm_j_fmt;
                br_op_o  = BR_JUMP;
                wb_en_o  = 1'b1;
                wb_sel_o = WB_PC4;
            end
            // Anything else retires as a bubble
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* pipeline/exec_unit.sv */
// Execute stage ALU plus branch and jump resolution
`timescale 1ns/100ps
`default_nettype none

module exec_unit
    import core_pkg::*;
(
    input  wire logic [XLEN-1:0] pc_i,
    input  wire logic [XLEN-1:0] rs1_i,
    input  wire logic [XLEN-1:0] rs2_i,
    input  wire logic [XLEN-1:0] imm_i,
    input  wire alu_op_e         alu_op_i,
    input  wire br_op_e          br_op_i,
    input  wire logic            alu_src_imm_i,
    output logic      [XLEN-1:0] result_o,
    output logic                 redirect_o,
    output logic      [XLEN-1:0] target_o
);

    logic [XLEN-1:0] op_b;

    assign op_b = alu_src_imm_i ? imm_i : rs2_i;

    always_comb begin
        case (alu_op_i)
            ALU_ADD:    result_o = rs1_i + op_b;
            ALU_SUB:    result_o = rs1_i - op_b;
            ALU_SLL:    result_o = rs1_i << op_b[4:0];
            ALU_SLT:    result_o = {{(XLEN-1){1'b0}}, $signed(rs1_i) < $signed(op_b)};
            ALU_XOR:    result_o = rs1_i ^ op_b;
            ALU_SRL:    result_o = rs1_i >> op_b[4:0];
            ALU_OR:     result_o = rs1_i | op_b;
            ALU_AND:    result_o = rs1_i & op_b;
            ALU_PASS_B: result_o = op_b;
            default:    result_o = '0;
        endcase
    end

    // ----------------------------------------
    // Branch decision
    // ----------------------------------------
    always_comb begin
        case (br_op_i)
            BR_EQ:   redirect_o = (rs1_i == rs2_i);
            BR_NE:   redirect_o = (rs1_i != rs2_i);
            BR_LT:   redirect_o = ($signed(rs1_i) < $signed(rs2_i));
            BR_JUMP: redirect_o = 1'b1;
            default: redirect_o = 1'b0;
        endcase
    end

    // Branches and JAL are both PC relative
    assign target_o = pc_i + imm_i;

endmodule

`default_nettype wire

/* pipeline/hazard_unit.sv */
// Operand forwarding muxes and load-use stall detection
`timescale 1ns/100ps
`default_nettype none

module hazard_unit
    import core_pkg::*;
(
    input  wire logic [REG_IDX_W-1:0] ex_rs1_i,
    input  wire logic [REG_IDX_W-1:0] ex_rs2_i,
    input  wire logic [XLEN-1:0]      ex_rs1_val_i,
    input  wire logic [XLEN-1:0]      ex_rs2_val_i,
    input  wire logic                 mem_valid_i,
    input  wire logic                 mem_wb_en_i,
    input  wire logic                 mem_is_load_i,
    input  wire logic [REG_IDX_W-1:0] mem_rd_i,
    input  wire logic [XLEN-1:0]      mem_val_i,
    input  wire logic                 wb_valid_i,
    input  wire logic [REG_IDX_W-1:0] wb_rd_i,
    input  wire logic [XLEN-1:0]      wb_val_i,
    input  wire logic                 ex_valid_i,
    input  wire logic                 ex_is_load_i,
    input  wire logic [REG_IDX_W-1:0] ex_rd_i,
    input  wire logic [REG_IDX_W-1:0] id_rs1_i,
    input  wire logic [REG_IDX_W-1:0] id_rs2_i,
    input  wire logic                 id_uses_rs2_i,
    output logic      [XLEN-1:0]      fwd_rs1_o,
    output logic      [XLEN-1:0]      fwd_rs2_o,
    output logic                      load_use_o
);

    logic mem_fwd_ok;
    logic wb_fwd_ok;

    // A load in MEM still waiting for its data has nothing to forward
    assign mem_fwd_ok = mem_valid_i && mem_wb_en_i && !mem_is_load_i && (mem_rd_i != '0);
    assign wb_fwd_ok  = wb_valid_i && (wb_rd_i != '0);

    // EX/MEM is younger, so it wins over MEM/WB
    always_comb begin
        fwd_rs1_o = ex_rs1_val_i;
        if (mem_fwd_ok && (mem_rd_i == ex_rs1_i)) begin
            fwd_rs1_o = mem_val_i;
        end else if (wb_fwd_ok && (wb_rd_i == ex_rs1_i)) begin
            fwd_rs1_o = wb_val_i;
        end
        fwd_rs2_o = ex_rs2_val_i;
        if (mem_fwd_ok && (mem_rd_i == ex_rs2_i)) begin
            fwd_rs2_o = mem_val_i;
        end else if (wb_fwd_ok && (wb_rd_i == ex_rs2_i)) begin
            fwd_rs2_o = wb_val_i;
        end
    end

    assign load_use_o = ex_valid_i && ex_is_load_i && (ex_rd_i != '0) &&
                        ((ex_rd_i == id_rs1_i) || (id_uses_rs2_i && (ex_rd_i == id_rs2_i)));

endmodule

`default_nettype wire

/* pipeline/lsu.sv */
// Load/store unit with one outstanding data-memory request and pipeline hold
`timescale 1ns/100ps
`default_nettype none

module lsu
    import core_pkg::*;
(
    input  wire logic            clk,
    input  wire logic            rst_n,
    input  wire logic            valid_i,
    input  wire logic            is_load_i,
    input  wire logic            is_store_i,
    input  wire logic [XLEN-1:0] addr_i,
    input  wire logic [XLEN-1:0] wdata_i,
    input  wire logic            dmem_resp_valid_i,
    input  wire logic [XLEN-1:0] dmem_resp_rdata_i,
    output logic                 dmem_req_valid_o,
    output logic                 dmem_req_write_o,
    output logic      [XLEN-1:0] dmem_req_addr_o,
    output logic      [XLEN-1:0] dmem_req_wdata_o,
    output logic                 mem_wait_o,
    output logic      [XLEN-1:0] load_data_o
);

    logic            mem_op;
    logic            pending_q;
    logic [XLEN-1:0] load_q;

    assign mem_op = valid_i && (is_load_i || is_store_i);

    // One-cycle request strobe on the first cycle of the operation
    assign dmem_req_valid_o = mem_op && !pending_q;
    assign dmem_req_write_o = is_store_i;
    assign dmem_req_addr_o  = {addr_i[XLEN-1:2], 2'b00};
    assign dmem_req_wdata_o = wdata_i;

    // Hold everything up to MEM until the response pulse
    assign mem_wait_o = mem_op && !dmem_resp_valid_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending_q <= 1'b0;
        end else if (dmem_resp_valid_i) begin
            pending_q <= 1'b0;
        end else if (dmem_req_valid_o) begin
            pending_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (dmem_resp_valid_i && is_load_i) begin
            load_q <= dmem_resp_rdata_i;
        end
    end

    assign load_data_o = dmem_resp_valid_i ? dmem_resp_rdata_i : load_q;

    // The response comes at the earliest one cycle after the request
    a_no_req_while_pending: assert property (@(posedge clk) disable iff (!rst_n)
        dmem_req_valid_o |=> !dmem_req_valid_o)
        else $error("lsu: request issued while one is outstanding");

    a_no_resp_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
        dmem_resp_valid_i |-> pending_q)
        else $error("lsu: response without outstanding request");

endmodule

`default_nettype wire

/* logic/rv32_core.sv */
// RV32I five-stage core top: PC, pipeline registers, stall/flush control, stage instances
`timescale 1ns/100ps
`default_nettype none

module rv32_core
    import core_pkg::*;
#(
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    output logic      [XLEN-1:0]      imem_addr_o,
    input  wire logic [XLEN-1:0]      imem_rdata_i,
    output logic                      dmem_req_valid_o,
    output logic                      dmem_req_write_o,
    output logic      [XLEN-1:0]      dmem_req_addr_o,
    output logic      [XLEN-1:0]      dmem_req_wdata_o,
    input  wire logic                 dmem_resp_valid_i,
    input  wire logic [XLEN-1:0]      dmem_resp_rdata_i,
    output logic                      wb_valid_o,
    output logic      [REG_IDX_W-1:0] wb_rd_o,
    output logic      [XLEN-1:0]      wb_data_o,
    output logic      [XLEN-1:0]      dbg_pc_o,
    output logic      [XLEN-1:0]      dbg_insn_o
);

    // ----------------------------------------
    // Stage signals
    // ----------------------------------------
    logic [XLEN-1:0]      pc_q;
    logic                 if_id_valid;
    logic [XLEN-1:0]      if_id_pc, if_id_insn;

    logic [REG_IDX_W-1:0] dec_rs1, dec_rs2, dec_rd;
    logic [XLEN-1:0]      dec_imm, rf_rdata1, rf_rdata2;
    alu_op_e              dec_alu_op;
    br_op_e               dec_br_op;
    wb_sel_e              dec_wb_sel;
    logic                 dec_alu_src_imm, dec_uses_rs2, dec_mem_read, dec_mem_write;
    logic                 dec_wb_en;

    logic                 id_ex_valid;
    logic [XLEN-1:0]      id_ex_pc, id_ex_imm, id_ex_rs1_val, id_ex_rs2_val;
    logic [REG_IDX_W-1:0] id_ex_rs1, id_ex_rs2, id_ex_rd;
    alu_op_e              id_ex_alu_op;
    br_op_e               id_ex_br_op;
    wb_sel_e              id_ex_wb_sel;
    logic                 id_ex_alu_src_imm, id_ex_mem_read, id_ex_mem_write, id_ex_wb_en;

    logic [XLEN-1:0]      fwd_rs1, fwd_rs2, alu_result, ex_target, ex_result;
    logic                 ex_redirect, redirect;

    logic                 ex_mem_valid;
    logic [XLEN-1:0]      ex_mem_result, ex_mem_rs2;
    logic [REG_IDX_W-1:0] ex_mem_rd;
    wb_sel_e              ex_mem_wb_sel;
    logic                 ex_mem_mem_read, ex_mem_mem_write, ex_mem_wb_en;

    logic                 mem_wait, load_use, mem_load_busy, fetch_adv;
    logic [XLEN-1:0]      load_data, mem_result;

    logic                 mem_wb_valid;
    logic [REG_IDX_W-1:0] mem_wb_rd;
    logic [XLEN-1:0]      mem_wb_data;

    assign redirect      = id_ex_valid && ex_redirect;
    assign fetch_adv     = !mem_wait && !redirect && !load_use;
    assign mem_load_busy = ex_mem_mem_read && mem_wait;

    // ----------------------------------------
    // Fetch and IF/ID
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q        <= RESET_PC;
            if_id_valid <= 1'b0;
            if_id_insn  <= NOP_INSN;
        end else if (!mem_wait && redirect) begin
            pc_q        <= ex_target;
            if_id_valid <= 1'b0;
            if_id_insn  <= NOP_INSN;
        end else if (fetch_adv) begin
            pc_q        <= pc_q + XLEN'(4);
            if_id_valid <= 1'b1;
            if_id_insn  <= imem_rdata_i;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_adv) begin
            if_id_pc <= pc_q;
        end
    end

    // ----------------------------------------
    // Decode and ID/EX
    // ----------------------------------------
    regfile regfile_inst (
        .clk(clk), .rst_n(rst_n),
        .we_i(mem_wb_valid), .waddr_i(mem_wb_rd), .wdata_i(mem_wb_data),
        .raddr1_i(dec_rs1), .raddr2_i(dec_rs2),
        .rdata1_o(rf_rdata1), .rdata2_o(rf_rdata2)
    );

    decode_unit decode_unit_inst (
        .insn_i(if_id_insn),
        .rs1_o(dec_rs1), .rs2_o(dec_rs2), .rd_o(dec_rd), .imm_o(dec_imm),
        .alu_op_o(dec_alu_op), .br_op_o(dec_br_op), .alu_src_imm_o(dec_alu_src_imm),
        .uses_rs2_o(dec_uses_rs2), .mem_read_o(dec_mem_read), .mem_write_o(dec_mem_write),
        .wb_en_o(dec_wb_en), .wb_sel_o(dec_wb_sel)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_ex_valid <= 1'b0;
        end else if (!mem_wait) begin
            id_ex_valid <= if_id_valid && !redirect && !load_use;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_wait) begin
            // Held EX operands still pick up results retiring from WB
            id_ex_rs1_val <= fwd_rs1;
            id_ex_rs2_val <= fwd_rs2;
        end else begin
            id_ex_pc          <= if_id_pc;
            id_ex_rs1         <= dec_rs1;
            id_ex_rs2         <= dec_rs2;
            id_ex_rd          <= dec_rd;
            id_ex_rs1_val     <= rf_rdata1;
            id_ex_rs2_val     <= rf_rdata2;
            id_ex_imm         <= dec_imm;
            id_ex_alu_op      <= dec_alu_op;
            id_ex_br_op       <= dec_br_op;
            id_ex_alu_src_imm <= dec_alu_src_imm;
            id_ex_mem_read    <= dec_mem_read;
            id_ex_mem_write   <= dec_mem_write;
            id_ex_wb_en       <= dec_wb_en;
            id_ex_wb_sel      <= dec_wb_sel;
        end
    end

    // ----------------------------------------
    // Execute and EX/MEM
    // ----------------------------------------
    hazard_unit hazard_unit_inst (
        .ex_rs1_i(id_ex_rs1), .ex_rs2_i(id_ex_rs2),
        .ex_rs1_val_i(id_ex_rs1_val), .ex_rs2_val_i(id_ex_rs2_val),
        .mem_valid_i(ex_mem_valid), .mem_wb_en_i(ex_mem_wb_en),
        .mem_is_load_i(mem_load_busy), .mem_rd_i(ex_mem_rd), .mem_val_i(mem_result),
        .wb_valid_i(mem_wb_valid), .wb_rd_i(mem_wb_rd), .wb_val_i(mem_wb_data),
        .ex_valid_i(id_ex_valid), .ex_is_load_i(id_ex_mem_read), .ex_rd_i(id_ex_rd),
        .id_rs1_i(dec_rs1), .id_rs2_i(dec_rs2), .id_uses_rs2_i(dec_uses_rs2),
        .fwd_rs1_o(fwd_rs1), .fwd_rs2_o(fwd_rs2), .load_use_o(load_use)
    );

    exec_unit exec_unit_inst (
        .pc_i(id_ex_pc), .rs1_i(fwd_rs1), .rs2_i(fwd_rs2), .imm_i(id_ex_imm),
        .alu_op_i(id_ex_alu_op), .br_op_i(id_ex_br_op), .alu_src_imm_i(id_ex_alu_src_imm),
        .result_o(alu_result), .redirect_o(ex_redirect), .target_o(ex_target)
    );

    // JAL link value
    assign ex_result = (id_ex_wb_sel == WB_PC4) ? id_ex_pc + XLEN'(4) : alu_result;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_mem_valid <= 1'b0;
        end else if (!mem_wait) begin
            ex_mem_valid <= id_ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!mem_wait) begin
            ex_mem_result    <= ex_result;
            ex_mem_rs2       <= fwd_rs2;
            ex_mem_rd        <= id_ex_rd;
            ex_mem_wb_sel    <= id_ex_wb_sel;
            ex_mem_mem_read  <= id_ex_mem_read;
            ex_mem_mem_write <= id_ex_mem_write;
            ex_mem_wb_en     <= id_ex_wb_en;
        end
    end

    // ----------------------------------------
    // Memory and MEM/WB
    // ----------------------------------------
    lsu lsu_inst (
        .clk(clk), .rst_n(rst_n),
        .valid_i(ex_mem_valid), .is_load_i(ex_mem_mem_read), .is_store_i(ex_mem_mem_write),
        .addr_i(ex_mem_result), .wdata_i(ex_mem_rs2),
        .dmem_resp_valid_i(dmem_resp_valid_i), .dmem_resp_rdata_i(dmem_resp_rdata_i),
        .dmem_req_valid_o(dmem_req_valid_o), .dmem_req_write_o(dmem_req_write_o),
        .dmem_req_addr_o(dmem_req_addr_o), .dmem_req_wdata_o(dmem_req_wdata_o),
        .mem_wait_o(mem_wait), .load_data_o(load_data)
    );

    always_comb begin
        case (ex_mem_wb_sel)
            WB_MEM:  mem_result = load_data;
            default: mem_result = ex_mem_result;
        endcase
    end

    // Only writes to x1..x31 retire through the write port
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_wb_valid <= 1'b0;
        end else begin
            mem_wb_valid <= !mem_wait && ex_mem_valid && ex_mem_wb_en && (ex_mem_rd != '0);
        end
    end

    always_ff @(posedge clk) begin
        mem_wb_rd   <= ex_mem_rd;
        mem_wb_data <= mem_result;
    end

    assign imem_addr_o = pc_q;
    assign wb_valid_o  = mem_wb_valid;
    assign wb_rd_o     = mem_wb_rd;
    assign wb_data_o   = mem_wb_data;
    assign dbg_pc_o    = pc_q;
    assign dbg_insn_o  = if_id_insn;

endmodule

`default_nettype wire

/* test/tb_program.svh */
// Test program image, expected register writebacks and expected data-memory stores
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

localparam int          PROG_LEN   = 40;
localparam logic [31:0] LOOP_PC    = 32'h0000_009C;
localparam logic [4:0]  MARKER_REG = 5'd31;

// ----------------------------------------
// Program, four words per line from 0x00
// ----------------------------------------
localparam logic [31:0] PROG [0:PROG_LEN-1] = '{
    // Dependent ALU chain: addi x1, addi x2, add x3, sub x4
    32'h0050_0093, 32'h0070_8113, 32'h0020_81B3, 32'h4011_8233,
    // sll x5, xor x6, srl x7, slti x8
    32'h0012_12B3, 32'h0032_C333, 32'h0013_53B3, 32'h00D3_A413,
    // lui x9, ori x9, andi x10, xori x11 with -1
    32'h1234_54B7, 32'h6784_E493, 32'h0FF4_F513, 32'hFFF5_4593,
    // slt x12, or x13, and x14, sw x9 to 0x100
    32'h0015_A633, 32'h0085_66B3, 32'h00D4_F733, 32'h1090_2023,
    // sw x3 to 0x104, lw x15, add x16 (load-use), lw x17
    32'h1030_2223, 32'h1000_2783, 32'h0017_8833, 32'h1040_2883,
    // add x18 (load-use), beq taken, two markers
    32'h0118_8933, 32'h0041_0663, 32'h0010_0F93, 32'h0010_0F93,
    // bne not taken, addi x19, bne taken, marker
    32'h0010_9463, 32'h0550_0993, 32'h0020_9663, 32'h0010_0F93,
    // marker, blt taken, two markers
    32'h0010_0F93, 32'h0015_C663, 32'h0010_0F93, 32'h0010_0F93,
    // blt not taken, beq not taken, jal x20, marker
    32'h00B0_C463, 32'h0020_8463, 32'h00C0_0A6F, 32'h0010_0F93,
    // marker, addi x21 from link, sw x21 to 0x108, jal x0 self-loop
    32'h0010_0F93, 32'h004A_0A93, 32'h1150_2423, 32'h0000_006F
};

// ----------------------------------------
// Writebacks in program order
// ----------------------------------------
localparam int WB_COUNT = 22;

localparam logic [4:0] EXP_WB_RD [0:WB_COUNT-1] = '{
    5'd1,  5'd2,  5'd3,  5'd4,  5'd5,  5'd6,  5'd7,  5'd8,
    5'd9,  5'd9,  5'd10, 5'd11, 5'd12, 5'd13, 5'd14, 5'd15,
    5'd16, 5'd17, 5'd18, 5'd19, 5'd20, 5'd21
};

localparam logic [31:0] EXP_WB_DATA [0:WB_COUNT-1] = '{
    32'h0000_0005, 32'h0000_000C, 32'h0000_0011, 32'h0000_000C,
    32'h0000_0180, 32'h0000_0191, 32'h0000_000C, 32'h0000_0001,
    32'h1234_5000, 32'h1234_5678, 32'h0000_0078, 32'hFFFF_FF87,
    32'h0000_0001, 32'h0000_0079, 32'h0000_0078, 32'h1234_5678,
    32'h1234_567D, 32'h0000_0011, 32'h0000_0022, 32'h0000_0055,
    32'h0000_008C, 32'h0000_0090
};

// Stores in program order
localparam int ST_COUNT = 3;

localparam logic [31:0] EXP_ST_ADDR [0:ST_COUNT-1] = '{
    32'h0000_0100, 32'h0000_0104, 32'h0000_0108
};

localparam logic [31:0] EXP_ST_DATA [0:ST_COUNT-1] = '{
    32'h1234_5678, 32'h0000_0011, 32'h0000_0090
};

`endif

/* test/core_tb.sv */
// Testbench for rv32_core: clock, reset, memory models, LFSR, checks and watchdog
`timescale 1ns/100ps
`default_nettype none

module core_tb;

    localparam int          HALF_PERIOD  = 5;
    localparam int          RESET_CYCLES = 16;
    localparam int          IMEM_WORDS   = 64;
    localparam int          DMEM_WORDS   = 256;
    localparam logic [31:0] NOP_WORD     = 32'h0000_0013;

    `include "tb_program.svh"

    localparam int WATCHDOG_CYCLES = PROG_LEN * 40 + RESET_CYCLES;

    logic        clk;
    logic        rst_n;
    logic [31:0] imem_addr;
    logic [31:0] imem_rdata;
    logic        dmem_req_valid;
    logic        dmem_req_write;
    logic [31:0] dmem_req_addr;
    logic [31:0] dmem_req_wdata;
    logic        dmem_resp_valid = 1'b0;
    logic [31:0] dmem_resp_rdata = '0;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;
    logic [31:0] dbg_pc;
    logic [31:0] dbg_insn;

    logic [31:0] imem [0:IMEM_WORDS-1];
    logic [31:0] dmem [0:DMEM_WORDS-1];
    logic [31:0] lfsr = 32'hb77;
    logic        resp_pending = 1'b0;
    logic [31:0] resp_data = '0;
    int          resp_delay = 0;
    int          wb_seen = 0;
    int          st_seen = 0;

    rv32_core #(
        .RESET_PC(32'h0)
    ) rv32_core_inst (
        .clk(clk), .rst_n(rst_n),
        .imem_addr_o(imem_addr), .imem_rdata_i(imem_rdata),
        .dmem_req_valid_o(dmem_req_valid), .dmem_req_write_o(dmem_req_write),
        .dmem_req_addr_o(dmem_req_addr), .dmem_req_wdata_o(dmem_req_wdata),
        .dmem_resp_valid_i(dmem_resp_valid), .dmem_resp_rdata_i(dmem_resp_rdata),
        .wb_valid_o(wb_valid), .wb_rd_o(wb_rd), .wb_data_o(wb_data),
        .dbg_pc_o(dbg_pc), .dbg_insn_o(dbg_insn)
    );

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic report_mismatch(input string test_name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("ERROR %s: expected 0x%08h, actual 0x%08h", test_name, expected, actual);
        abort_run($sformatf("%s check did not match", test_name));
    endtask

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    // One LFSR step per delay bit
    task automatic draw_delay(output int cycles);
        logic [1:0] bits;
        for (int i = 0; i < 2; i++) begin
            lfsr    = lfsr_step(lfsr);
            bits[i] = lfsr[0];
        end
        cycles = int'(bits) + 1;
    endtask

    // Word fetched one slot before the given PC
    function automatic logic [31:0] prev_fetch_word(input logic [31:0] pc);
        return imem[pc[7:2] - 6'd1];
    endfunction

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // ----------------------------------------
    // Memory models
    // ----------------------------------------
    assign imem_rdata = imem[imem_addr[7:2]];

    // Requests sampled mid-cycle, response pulse 1 to 4 cycles later
    always @(negedge clk) begin
        dmem_resp_valid = 1'b0;
        if (resp_pending) begin
            if (resp_delay <= 1) begin
                dmem_resp_valid = 1'b1;
                dmem_resp_rdata = resp_data;
                resp_pending    = 1'b0;
            end else begin
                resp_delay = resp_delay - 1;
            end
        end
        if (rst_n && dmem_req_valid) begin
            assert (!resp_pending)
                else abort_run("data memory got a second request before its response");
            if (dmem_req_write) begin
                assert (st_seen < ST_COUNT)
                    else abort_run("more stores issued than the program contains");
                assert (dmem_req_addr == EXP_ST_ADDR[st_seen])
                    else report_mismatch("store_addr", EXP_ST_ADDR[st_seen], dmem_req_addr);
                assert (dmem_req_wdata == EXP_ST_DATA[st_seen])
                    else report_mismatch("store_data", EXP_ST_DATA[st_seen], dmem_req_wdata);
                dmem[dmem_req_addr[9:2]] = dmem_req_wdata;
                st_seen = st_seen + 1;
            end
            resp_data    = dmem[dmem_req_addr[9:2]];
            resp_pending = 1'b1;
            draw_delay(resp_delay);
        end
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    a_reset_quiet: assert property (@(posedge clk)
        (!rst_n || $rose(rst_n)) |-> !(dmem_req_valid || wb_valid))
        else report_mismatch("reset_quiet", 32'h0, {30'h0, dmem_req_valid, wb_valid});

    a_reset_pc: assert property (@(posedge clk) (!rst_n || $rose(rst_n)) |-> (dbg_pc == '0))
        else report_mismatch("reset_pc", 32'h0, dbg_pc);

    // IF/ID holds the word fetched just before the current PC, or a bubble
    a_dbg_insn: assert property (@(posedge clk) disable iff (!rst_n)
        (dbg_insn == NOP_WORD) || (dbg_insn == prev_fetch_word(dbg_pc)))
        else report_mismatch("dbg_insn", prev_fetch_word(dbg_pc), dbg_insn);

    a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid |-> (wb_rd != 5'd0))
        else abort_run("a write to x0 appeared on the writeback trace");

    always @(posedge clk) begin
        if (rst_n && wb_valid) begin
            // Marker only reachable through a squashed instruction
            assert (wb_rd != MARKER_REG)
                else abort_run("an instruction after a taken branch or JAL wrote x31");
            assert (wb_seen < WB_COUNT)
                else abort_run("more register writebacks than the program produces");
            assert (wb_rd == EXP_WB_RD[wb_seen])
                else report_mismatch("writeback_rd", 32'(EXP_WB_RD[wb_seen]), 32'(wb_rd));
            assert (wb_data == EXP_WB_DATA[wb_seen])
                else report_mismatch("writeback_data", EXP_WB_DATA[wb_seen], wb_data);
            wb_seen = wb_seen + 1;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        abort_run("Timeout: program did not reach its final loop in time");
    end

    initial begin
        int drain;
        rst_n = 1'b0;
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = (i < PROG_LEN) ? PROG[i] : NOP_WORD;
        end
        // Fill depends on the full word address
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] = 32'(i * 4) ^ 32'h5A5A_5A5A;
        end
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        while (!((dbg_pc == LOOP_PC) && (wb_seen == WB_COUNT))) begin
            @(negedge clk);
        end
        // Last store may still be on its way to MEM
        drain = 0;
        while ((st_seen < ST_COUNT) && (drain < 8)) begin
            @(negedge clk);
            drain = drain + 1;
        end
        if (st_seen == ST_COUNT) begin
            $display("Simulation passed");
            $finish;
        end else begin
            abort_run("program reached its final loop with stores missing");
        end
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+test
common/core_pkg.sv
logic/regfile.sv
pipeline/decode_unit.sv
pipeline/exec_unit.sv
pipeline/hazard_unit.sv
pipeline/lsu.sv
logic/rv32_core.sv
test/core_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the rv32_core testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module core_tb -f all.f -o core_tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/core_tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
    exit 1
fi
exit 0
